// ==== y_dct.f ====
+incdir+verilog
+incdir+verif
verilog/dct_pkg.sv
verilog/dct_sequencer.sv
verilog/dct_row_pass.sv
verilog/dct_col_pass.sv
verilog/y_dct_top.sv
verif/y_dct_assertions.sv
verif/y_dct_tb.sv

// ==== verif/y_dct_model.svh ====
/*
 * Reference model of the luma DCT
 * Row and column passes in plain integer arithmetic with wrap and rounding
 */

`ifndef Y_DCT_MODEL_SVH
`define Y_DCT_MODEL_SVH

// Scaled cosine table entry, computed in floating point and rounded to nearest
function automatic int ref_basis(input int k, input int n);
	real x;
	if (k == 0)
		return `BASIS_DC;
	x = 8192.0 * $cos((2 * n + 1) * k * 3.14159265358979 / 16.0);
	if (x >= 0.0)
		return $rtoi(x + 0.5);
	return -$rtoi(0.5 - x);
endfunction

// Two's complement wrap of v into w bits
function automatic int wrap_to(input longint v, input int w);
	longint m;
	m = v & ((longint'(1) << w) - 1);
	if (m >= (longint'(1) << (w - 1)))
		m = m - (longint'(1) << w);
	return int'(m);
endfunction

// Drop everything up to bit lsb, add bit lsb back as rounding, keep w bits
function automatic int round_keep(input longint v, input int lsb, input int w);
	longint t;
	t = (v >>> (lsb + 1)) + ((v >>> lsb) & 1);
	return wrap_to(t, w);
endfunction

// Pixel p of row r sits at px[(r*8+p)*8 +: 8]
function automatic coef_block_t model_block(input logic [511:0] px);
	int res [0:7][0:7];
	longint sum;
	coef_block_t blk;
	for (int r = 0; r < 8; r++) begin
		for (int k = 0; k < 8; k++) begin
			sum = 0;
			for (int n = 0; n < 8; n++)
				sum += longint'(px[(r * 8 + n) * 8 +: 8]) * ref_basis(k, n);
			sum = wrap_to(sum, `ROW_ACC_W);
			if (k == 0)
				sum = wrap_to(sum - `LEVEL_SHIFT, `ROW_ACC_W);
			res[r][k] = round_keep(sum, `ROW_ROUND_BIT, `ROW_RES_W);
		end
	end
	// Second pass runs down the columns, row index n picks the basis column
	for (int k = 0; k < 8; k++) begin
		for (int j = 0; j < 8; j++) begin
			sum = 0;
			for (int n = 0; n < 8; n++)
				sum += longint'(res[n][k]) * ref_basis(j, n);
			sum = wrap_to(sum, `BLK_ACC_W);
			blk.coef[k][j] = coef_t'(round_keep(sum, `BLK_ROUND_BIT, `COEF_W));
		end
	end
	return blk;
endfunction

`endif

// ==== verif/y_dct_tb.sv ====
/*
 * Luma DCT testbench
 * Flat, random, back-to-back and aborted blocks checked against the model
 */

`timescale 1ns/10ps
`include "dct_consts.svh"

module y_dct_tb import dct_pkg::*; ();

	`include "y_dct_model.svh"

	localparam int CLK_PERIOD = 100;
	localparam int TOTAL_PIXELS = 3 * 64 + 8 * 64 + 30 + 64;

	// What a block must show beyond matching the model
	localparam int KIND_ANY = 0;
	localparam int KIND_ZERO = 1;
	localparam int KIND_DC_NEG = 2;
	localparam int KIND_DC_POS = 3;

	logic        clk;
	logic        rst;
	logic        pixel_valid;
	pixel_t      pixel;
	coef_block_t coefs;
	logic        coef_valid;

	logic [16:0] lfsr_state;
	coef_block_t expected_q[$];
	int          kind_q[$];

	y_dct_top y_dct_top_i (
		.clk         (clk),
		.rst         (rst),
		.pixel_valid (pixel_valid),
		.pixel       (pixel),
		.coefs       (coefs),
		.coef_valid  (coef_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	// Taps 17 and 14 with one step per bit taken
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic make_random_block(output logic [511:0] px);
		for (int i = 0; i < 512; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			px[i] = lfsr_state[0];
		end
	endtask

	function automatic logic [511:0] flat_block(input pixel_t v);
		return {64{v}};
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			pixel_valid = 1'b0;
			pixel = '0;
		end
	endtask

	task automatic drive_pixels(input logic [511:0] px, input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			pixel_valid = 1'b1;
			pixel = px[i * 8 +: 8];
		end
	endtask

	task automatic drive_block(input logic [511:0] px, input int kind);
		drive_pixels(px, 64);
		expected_q.push_back(model_block(px));
		kind_q.push_back(kind);
	endtask

	task automatic check_block();
		coef_block_t want;
		int kind;
		assert (expected_q.size() != 0)
		else fail_now("coefficient block arrived with no block expected");
		want = expected_q.pop_front();
		kind = kind_q.pop_front();
		for (int k = 0; k < 8; k++) begin
			for (int j = 0; j < 8; j++) begin
				assert (coefs.coef[k][j] === want.coef[k][j])
				else fail_now($sformatf("Error coefs[%0d][%0d] expected %h actual %h",
					k, j, want.coef[k][j], coefs.coef[k][j]));
			end
		end
		case (kind)
			KIND_ZERO:
				assert (coefs == '0)
				else fail_now("flat mid-gray block gave nonzero coefficients");
			KIND_DC_NEG:
				assert ($signed(coefs.coef[0][0]) < -512)
				else fail_now("flat black block gave no large negative DC term");
			KIND_DC_POS:
				assert ($signed(coefs.coef[0][0]) > 512)
				else fail_now("flat white block gave no large positive DC term");
			default: ;
		endcase
	endtask

	// Outputs are sampled mid-cycle, away from the rising edge
	always @(negedge clk) begin
		if (!rst && coef_valid)
			check_block();
	end

	always @(negedge clk) begin
		if (y_dct_top_i.y_dct_assertions_i.fail_count != 0)
			fail_now("a bound assertion on the DUT failed");
	end

	initial begin
		#((TOTAL_PIXELS + 200) * CLK_PERIOD);
		fail_now("timeout waiting for coefficient block");
	end

	initial begin
		logic [511:0] px;
		clk = 1'b0;
		rst = 1'b1;
		pixel_valid = 1'b0;
		pixel = '0;
		lfsr_state = 17'd76079;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle(4);

		drive_block(flat_block(8'd128), KIND_ZERO);
		idle(12);
		drive_block(flat_block(8'd0), KIND_DC_NEG);
		idle(12);
		drive_block(flat_block(8'd255), KIND_DC_POS);
		idle(12);

		// Eight blocks with pixel_valid held high throughout
		for (int b = 0; b < 8; b++) begin
			make_random_block(px);
			drive_block(px, KIND_ANY);
		end
		idle(12);

		// A partial block is thrown away and the next one starts clean
		make_random_block(px);
		drive_pixels(px, 30);
		idle(4);
		make_random_block(px);
		drive_block(px, KIND_ANY);
		idle(1);

		// The last block is due 7 cycles after its final pixel
		for (int i = 0; i < 20 && expected_q.size() != 0; i++)
			@(negedge clk);
		idle(10);
		if (expected_q.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			fail_now("expected coefficient block never arrived");
		end
	end

endmodule

// ==== verif/y_dct_assertions.sv ====
/*
 * Luma DCT timing checks
 * Reset state, pulse width, block latency and output hold
 */

`timescale 1ns/10ps

module y_dct_assertions import dct_pkg::*; (
	input logic        clk,
	input logic        rst,
	input logic        pixel_valid,
	input logic        coef_valid,
	input coef_block_t coefs
);

	int fail_count = 0;

	logic [5:0] pix_cnt;
	logic       last_pixel;

	// Consecutive accepted pixels, restarted by any gap in pixel_valid
	always_ff @(posedge clk) begin
		if (rst || !pixel_valid)
			pix_cnt <= '0;
		else
			pix_cnt <= pix_cnt + 1'b1;
	end

	assign last_pixel = pixel_valid && (pix_cnt == 6'd63);

	reset_clears_output: assert property (@(posedge clk)
		rst |=> (!coef_valid && coefs == '0))
	else begin
		$error("coef_valid or coefs not cleared by reset");
		fail_count++;
	end

	pulse_one_cycle: assert property (@(posedge clk) disable iff (rst)
		coef_valid |=> !coef_valid)
	else begin
		$error("coef_valid high for more than one cycle");
		fail_count++;
	end

	block_latency: assert property (@(posedge clk) disable iff (rst)
		last_pixel |-> ##7 coef_valid)
	else begin
		$error("coef_valid missing 7 cycles after the last pixel of a block");
		fail_count++;
	end

	rise_needs_block: assert property (@(posedge clk) disable iff (rst)
		$rose(coef_valid) |-> $past(last_pixel, 7))
	else begin
		$error("coef_valid rose without a complete block 7 cycles before");
		fail_count++;
	end

	coefs_held: assert property (@(posedge clk) disable iff (rst)
		!$rose(coef_valid) |-> $stable(coefs))
	else begin
		$error("coefs changed without a coef_valid pulse");
		fail_count++;
	end

endmodule

bind y_dct_top y_dct_assertions y_dct_assertions_i (
	.clk         (clk),
	.rst         (rst),
	.pixel_valid (pixel_valid),
	.coef_valid  (coef_valid),
	.coefs       (coefs)
);

// ==== verilog/y_dct_top.sv ====
/*
 * Luma 8x8 forward DCT
 * Sequencer, row pass and column pass in a straight pipeline
 */

`timescale 1ns/10ps

module y_dct_top import dct_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        pixel_valid,
	input  pixel_t      pixel,
	output coef_block_t coefs,
	output logic        coef_valid
);

	logic     tag_valid;
	pixel_t   tag_pixel;
	idx_t     tag_col;
	idx_t     tag_row;
	logic     tag_row_end;

	logic     row_valid;
	row_vec_t row;

	dct_sequencer dct_sequencer_i (
		.clk         (clk),
		.rst         (rst),
		.pixel_valid (pixel_valid),
		.pixel       (pixel),
		.tag_valid   (tag_valid),
		.tag_pixel   (tag_pixel),
		.tag_col     (tag_col),
		.tag_row     (tag_row),
		.tag_row_end (tag_row_end)
	);

	dct_row_pass dct_row_pass_i (
		.clk         (clk),
		.rst         (rst),
		.tag_valid   (tag_valid),
		.tag_pixel   (tag_pixel),
		.tag_col     (tag_col),
		.tag_row     (tag_row),
		.tag_row_end (tag_row_end),
		.row_valid   (row_valid),
		.row         (row)
	);

	dct_col_pass dct_col_pass_i (
		.clk        (clk),
		.rst        (rst),
		.row_valid  (row_valid),
		.row        (row),
		.coef_valid (coef_valid),
		.coefs      (coefs)
	);

endmodule

// ==== verilog/dct_col_pass.sv ====
/*
 * DCT column pass
 * Multiplies row results by the transposed basis, accumulates the
 * block and rounds it to 11-bit coefficients held until the next block
 */

`timescale 1ns/10ps
`include "dct_consts.svh"

module dct_col_pass import dct_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        row_valid,
	input  row_vec_t    row,
	output logic        coef_valid,
	output coef_block_t coefs
);

	// Both arrays are indexed [k][j]
	logic [`DCT_N-1:0][`DCT_N-1:0][`BLK_ACC_W-1:0] prod;
	logic                                          prod_valid;
	logic                                          prod_first;
	logic                                          prod_last;

	logic [`DCT_N-1:0][`DCT_N-1:0][`BLK_ACC_W-1:0] acc;
	logic                                          blk_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			prod_last <= 1'b0;
		end else begin
			prod_valid <= row_valid;
			prod_last <= row_valid && (row.idx == '1);
		end
	end

	// Row index n selects the basis column, so this is the transposed matrix
	always_ff @(posedge clk) begin
		if (row_valid) begin
			for (int k = 0; k < `DCT_N; k++) begin
				for (int j = 0; j < `DCT_N; j++) begin
					prod[k][j] <= $signed(row.res[k]) * dct_basis(idx_t'(j), row.idx);
				end
			end
			prod_first <= (row.idx == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			blk_done <= 1'b0;
		else
			blk_done <= prod_last;
	end

	// Row 0 of a new block overwrites whatever an aborted block left behind
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			for (int k = 0; k < `DCT_N; k++) begin
				for (int j = 0; j < `DCT_N; j++) begin
					acc[k][j] <= prod_first ? prod[k][j] : acc[k][j] + prod[k][j];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			coef_valid <= 1'b0;
		else
			coef_valid <= blk_done;
	end

	// Keep bits 26..16 and round on bit 15
	always_ff @(posedge clk) begin
		if (rst) begin
			coefs <= '0;
		end else if (blk_done) begin
			for (int k = 0; k < `DCT_N; k++) begin
				for (int j = 0; j < `DCT_N; j++) begin
					coefs.coef[k][j] <= coef_t'(
						acc[k][j][`BLK_ROUND_BIT+`COEF_W:`BLK_ROUND_BIT+1] +
						acc[k][j][`BLK_ROUND_BIT]);
				end
			end
		end
	end

endmodule

// ==== verilog/dct_row_pass.sv ====
/*
 * DCT row pass
 * Multiplies each row by the basis matrix, removes the level shift
 * from the DC term and rounds the eight sums to 13 bits
 */

`timescale 1ns/10ps
`include "dct_consts.svh"

module dct_row_pass import dct_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     tag_valid,
	input  pixel_t   tag_pixel,
	input  idx_t     tag_col,
	input  idx_t     tag_row,
	input  logic     tag_row_end,
	output logic     row_valid,
	output row_vec_t row
);

	logic [`DCT_N-1:0][`ROW_ACC_W-1:0] prod;
	logic                              prod_valid;
	logic                              prod_first;
	logic                              prod_end;
	idx_t                              prod_row;

	logic [`DCT_N-1:0][`ROW_ACC_W-1:0] acc;
	logic                              acc_end;
	idx_t                              acc_row;

	logic [`DCT_N-1:0][`ROW_ACC_W-1:0] shifted;

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			prod_end <= 1'b0;
		end else begin
			prod_valid <= tag_valid;
			prod_end <= tag_valid && tag_row_end;
		end
	end

	// Pixels are unsigned, so a zero is put in front before the signed multiply
	always_ff @(posedge clk) begin
		if (tag_valid) begin
			for (int k = 0; k < `DCT_N; k++) begin
				prod[k] <= $signed({1'b0, tag_pixel}) * dct_basis(idx_t'(k), tag_col);
			end
			prod_first <= (tag_col == '0);
			prod_row <= tag_row;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			acc_end <= 1'b0;
		else
			acc_end <= prod_end;
	end

	// The first pixel of a row starts the sums over
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			for (int k = 0; k < `DCT_N; k++) begin
				acc[k] <= prod_first ? prod[k] : acc[k] + prod[k];
			end
			acc_row <= prod_row;
		end
	end

	// Only the DC sum carries the 128 offset; every other basis row sums to zero
	always_comb begin
		shifted = acc;
		shifted[0] = acc[0] - `ROW_ACC_W'(`LEVEL_SHIFT);
	end

	always_ff @(posedge clk) begin
		if (rst)
			row_valid <= 1'b0;
		else
			row_valid <= acc_end;
	end

	// Keep bits 24..12 and round on bit 11
	always_ff @(posedge clk) begin
		if (acc_end) begin
			for (int k = 0; k < `DCT_N; k++) begin
				row.res[k] <= row_res_t'(
					shifted[k][`ROW_ROUND_BIT+`ROW_RES_W:`ROW_ROUND_BIT+1] +
					shifted[k][`ROW_ROUND_BIT]);
			end
			row.idx <= acc_row;
		end
	end

endmodule

// ==== verilog/dct_sequencer.sv ====
/*
 * Pixel sequencer
 * Tracks column and row within the block and tags each accepted pixel
 */

`timescale 1ns/10ps

module dct_sequencer import dct_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   pixel_valid,
	input  pixel_t pixel,
	output logic   tag_valid,
	output pixel_t tag_pixel,
	output idx_t   tag_col,
	output idx_t   tag_row,
	output logic   tag_row_end
);

	idx_t col_cnt;
	idx_t row_cnt;

	// A gap in pixel_valid throws away the partial block
	always_ff @(posedge clk) begin
		if (rst || !pixel_valid) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else begin
			col_cnt <= col_cnt + 1'b1;
			if (col_cnt == '1)
				row_cnt <= row_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_valid <= 1'b0;
			tag_row_end <= 1'b0;
		end else begin
			tag_valid <= pixel_valid;
			tag_row_end <= pixel_valid && (col_cnt == '1);
		end
	end

	// Position travels with the pixel from here on
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			tag_pixel <= pixel;
			tag_col <= col_cnt;
			tag_row <= row_cnt;
		end
	end

endmodule

// ==== verilog/dct_pkg.sv ====
/*
 * Luma DCT types
 * Pixel, row result and coefficient block types plus the basis lookup
 */

`include "dct_consts.svh"

package dct_pkg;

	typedef logic [`PIXEL_W-1:0] pixel_t;
	typedef logic [$clog2(`DCT_N)-1:0] idx_t;
	typedef logic signed [14:0] basis_t;
	typedef logic signed [`ROW_RES_W-1:0] row_res_t;
	typedef logic signed [`COEF_W-1:0] coef_t;

	// One transformed row, tagged with the row it came from
	typedef struct packed {
		idx_t                       idx;
		row_res_t [`DCT_N-1:0]      res;
	} row_vec_t;

	// Indexed as coef[k][j], horizontal frequency first
	typedef struct packed {
		coef_t [`DCT_N-1:0][`DCT_N-1:0] coef;
	} coef_block_t;

	// Scaled DCT matrix entry for frequency k at position n
	function automatic basis_t dct_basis(input idx_t k, input idx_t n);
		logic [6:0] phase;
		logic [4:0] m;
		logic       neg;
		basis_t     mag;
		if (k == '0)
			return basis_t'(`BASIS_DC);
		// Angle in units of pi/16, folded into the first half turn
		phase = {n, 1'b1} * k;
		m = phase[4:0];
		if (m > 5'd16)
			m = 5'd0 - m;
		neg = (m > 5'd8);
		if (neg)
			m = 5'd16 - m;
		case (m)
			5'd0:    mag = 15'sd8192;
			5'd1:    mag = 15'sd8035;
			5'd2:    mag = 15'sd7568;
			5'd3:    mag = 15'sd6811;
			5'd4:    mag = basis_t'(`BASIS_DC);
			5'd5:    mag = 15'sd4551;
			5'd6:    mag = 15'sd3135;
			5'd7:    mag = 15'sd1598;
			default: mag = 15'sd0;
		endcase
		return neg ? -mag : mag;
	endfunction

endpackage

// ==== verilog/dct_consts.svh ====
/*
 * Luma DCT constants
 * Block size, datapath widths, level shift and rounding positions
 */

`ifndef DCT_CONSTS_SVH
`define DCT_CONSTS_SVH

// Block edge and pixel width
`define DCT_N          8
`define PIXEL_W        8

// Row pass accumulates in 25 bits and keeps 13 after rounding
`define ROW_ACC_W      25
`define ROW_RES_W      13
`define ROW_ROUND_BIT  11

// Column pass accumulates in 27 bits and keeps 11 after rounding
`define BLK_ACC_W      27
`define COEF_W         11
`define BLK_ROUND_BIT  15

// DC basis value, 8192 / sqrt(2) rounded
`define BASIS_DC       5793

// 128 * 8 * 5793, taken off the DC row sum instead of shifting each pixel
`define LEVEL_SHIFT    5932032

`endif
